/* Bender.yml */
package:
  name: cacheSystem

sources:
  - include_dirs:
      - design
    files:
      - design/cachePkg.sv
      - design/flushCounter.sv
      - design/cacheTagArray.sv
      - design/cacheDataArray.sv
      - design/cacheFsm.sv
      - design/cacheTop.sv
  - target: test
    include_dirs:
      - design
      - testbench
    files:
      - testbench/cacheTb.sv

/* cacheSystem.f */
+incdir+design
+incdir+testbench
design/cachePkg.sv
design/flushCounter.sv
design/cacheTagArray.sv
design/cacheDataArray.sv
design/cacheFsm.sv
design/cacheTop.sv
testbench/cacheTb.sv

/* design/cacheDataArray.sv */
////////////////////////////////////////
// Line data storage
// Word writes, line fills, fetch buffer
////////////////////////////////////////
`timescale 1ns/1ps
`include "cache_params.svh"

module cacheDataArray (
  input  logic                        clk,
  input  logic [`CACHE_ADR_BITS-1:0]  adr,
  input  cachePkg::wayIdxT            selectedWay,
  input  cachePkg::wordT              writeData,
  input  logic [1:0]                  cacheRW,
  input  logic                        setValid,      // Fill the whole line
  input  logic                        setDirty,      // Single word store
  input  cachePkg::lineT              busReadLine,
  input  logic                        busAck,
  input  logic                        selFetchBuffer,
  output cachePkg::wordT              readData,
  output cachePkg::lineT              busWriteLine
);

  cachePkg::lineT   lines [`CACHE_WAYS][`CACHE_SETS];
  cachePkg::lineT   fetchBuffer;   // Last line from the bus
  cachePkg::lineT   fillLine;
  cachePkg::lineT   storedLine;
  cachePkg::setIdxT setIdx;
  cachePkg::offsetT offset;

  assign setIdx = adr[cachePkg::OFFSET_BITS +: cachePkg::SET_BITS];
  assign offset = adr[cachePkg::OFFSET_BITS-1:0];

  // Capture on every ack
  always_ff @(posedge clk) begin
    if (busAck) fetchBuffer <= busReadLine;
  end

  // Write miss merges its word into the fetched line
  always_comb begin
    fillLine = fetchBuffer;
    if (cacheRW[0]) fillLine[offset] = writeData;
  end

  always_ff @(posedge clk) begin
    if (setValid) begin
      lines[selectedWay][setIdx] <= fillLine;
    end else if (setDirty) begin
      lines[selectedWay][setIdx][offset] <= writeData;   // Write hit
    end
  end

  assign storedLine   = lines[selectedWay][setIdx];
  assign busWriteLine = storedLine;   // Writeback source
  // Bypass while the fill is not yet readable
  assign readData = selFetchBuffer ? fetchBuffer[offset] : storedLine[offset];

endmodule

/* design/cacheFsm.sv */
////////////////////////////////////////
// Cache controller FSM
// Hits, miss fetch and writeback, flush walk
////////////////////////////////////////
`timescale 1ns/1ps

module cacheFsm (
  input  logic       clk,
  input  logic       reset,
  input  logic       stall,            // CPU holds the request
  input  logic [1:0] cacheRW,          // [1] read, [0] write
  input  logic       flushCache,       // Write back all dirty lines
  input  logic       invalidateCache,  // Drop every line
  input  logic       busAck,           // One-cycle line transfer done
  input  logic       cacheHit,
  input  logic       lineDirty,        // Selected way is valid and dirty
  input  logic       flushAdrFlag,     // Last set of the flush walk
  input  logic       flushWayFlag,     // Last way of the flush walk
  output logic       cacheStall,
  output logic [1:0] busRW,            // [1] fetch, [0] writeback
  output logic       cacheMiss,
  output logic       cacheAccess,
  output logic       selWriteback,     // busAdr from victim tag
  output logic       selFlush,         // Arrays indexed by flush counters
  output logic       setValid,
  output logic       setDirty,
  output logic       clearDirty,
  output logic       lruWriteEn,
  output logic       flushAdrCntEn,
  output logic       flushWayCntEn,
  output logic       flushCntRst,
  output logic       selFetchBuffer    // readData from the fill buffer
);

  cachePkg::cacheStateT currState;
  cachePkg::cacheStateT nextState;
  logic anyMiss;
  logic anyUpdateHit;
  logic anyHit;
  logic flushFlag;
  logic inReady;
  logic readyGo;      // READY and not frozen by stall
  logic readyHit;
  logic readyMiss;
  logic reqDone;

  assign anyMiss      = (|cacheRW) & ~cacheHit & ~invalidateCache;
  assign anyUpdateHit = cacheRW[0] & cacheHit;
  assign anyHit       = (|cacheRW) & cacheHit;
  assign flushFlag    = flushAdrFlag & flushWayFlag;   // Last entry of the walk

  assign inReady   = currState == cachePkg::READY;
  assign readyGo   = inReady & ~stall;
  // Invalidate and flush win over a pending request
  assign readyHit  = readyGo & ~flushCache & ~invalidateCache;
  assign readyMiss = readyGo & ~flushCache & anyMiss;

  always_ff @(posedge clk) begin
    if (reset) begin
      currState <= cachePkg::READY;
    end else begin
      currState <= nextState;
    end
  end

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////
  always_comb begin
    nextState = currState;
    case (currState)
      cachePkg::READY: begin
        if (stall)                 nextState = cachePkg::READY;   // Frozen
        else if (invalidateCache)  nextState = cachePkg::READY;   // Single cycle clear
        else if (flushCache)       nextState = cachePkg::FLUSH;
        else if (anyMiss & ~lineDirty) nextState = cachePkg::FETCH;
        else if (anyMiss)          nextState = cachePkg::WRITEBACK;
      end
      cachePkg::FETCH: begin
        if (busAck) nextState = cachePkg::WRITE_LINE;
      end
      cachePkg::WRITEBACK: begin
        if (busAck) nextState = cachePkg::FETCH;   // Victim gone, now fill
      end
      cachePkg::WRITE_LINE: nextState = cachePkg::READ_HOLD;
      cachePkg::READ_HOLD: begin
        if (!stall) nextState = cachePkg::READY;
      end
      cachePkg::FLUSH: begin
        if (lineDirty)      nextState = cachePkg::FLUSH_WRITEBACK;
        else if (flushFlag) nextState = cachePkg::READ_HOLD;
      end
      cachePkg::FLUSH_WRITEBACK: begin
        if (busAck & ~flushFlag) nextState = cachePkg::FLUSH;
        else if (busAck)         nextState = cachePkg::READ_HOLD;
      end
      default: nextState = cachePkg::READY;
    endcase
  end

  ////////////////////////////////////////
  // CPU side
  ////////////////////////////////////////
  assign cacheStall = (inReady & (flushCache | anyMiss)) |
                      (currState == cachePkg::FETCH) |
                      (currState == cachePkg::WRITEBACK) |
                      (currState == cachePkg::WRITE_LINE) |   // Array write cycle
                      (currState == cachePkg::FLUSH) |
                      (currState == cachePkg::FLUSH_WRITEBACK);

  // Count a request once, at the edge where it completes
  assign reqDone     = (|cacheRW) & ~stall & ~cacheStall &
                       (inReady | (currState == cachePkg::READ_HOLD));
  assign cacheAccess = reqDone;
  assign cacheMiss   = reqDone & (currState == cachePkg::READ_HOLD);   // Only misses end here

  // Array write enables
  assign setValid   = currState == cachePkg::WRITE_LINE;
  assign lruWriteEn = (readyHit & anyHit) | (currState == cachePkg::WRITE_LINE);
  assign setDirty   = (readyHit & anyUpdateHit) |
                      (currState == cachePkg::WRITE_LINE & cacheRW[0]);   // Write miss merge
  assign clearDirty = (currState == cachePkg::WRITE_LINE & ~cacheRW[0]) |
                      (currState == cachePkg::FLUSH & lineDirty);

  // Address selects
  assign selWriteback = (readyMiss & lineDirty) | (currState == cachePkg::WRITEBACK);
  assign selFlush     = (inReady & flushCache) |
                        (currState == cachePkg::FLUSH) |
                        (currState == cachePkg::FLUSH_WRITEBACK);
  assign selFetchBuffer = (currState == cachePkg::WRITE_LINE) |
                          (currState == cachePkg::READ_HOLD);

  ////////////////////////////////////////
  // Flush walk
  ////////////////////////////////////////
  assign flushWayCntEn = (currState == cachePkg::FLUSH & ~lineDirty) |
                         (currState == cachePkg::FLUSH_WRITEBACK & busAck);
  assign flushAdrCntEn = (currState == cachePkg::FLUSH & flushWayFlag & ~lineDirty) |
                         (currState == cachePkg::FLUSH_WRITEBACK & flushWayFlag & busAck);
  assign flushCntRst   = (currState == cachePkg::FLUSH & flushFlag & ~lineDirty) |
                         (currState == cachePkg::FLUSH_WRITEBACK & flushFlag & busAck);

  // Bus requests stay up through the busAck cycle
  assign busRW[1] = (readyMiss & ~lineDirty) | (currState == cachePkg::FETCH);
  assign busRW[0] = (readyMiss & lineDirty) |
                    (currState == cachePkg::WRITEBACK) |
                    (currState == cachePkg::FLUSH_WRITEBACK);

  // Fetch and writeback are never requested together
  assert property (@(posedge clk) disable iff (reset) !(busRW[1] && busRW[0]))
    else $error("busRW requests fetch and writeback together");

  // Memory sees one steady request until it answers
  assert property (@(posedge clk) disable iff (reset)
    (busRW != 2'b00 && !busAck) |=> busRW == $past(busRW))
    else $error("busRW changed before busAck");

endmodule

/* design/cachePkg.sv */
////////////////////////////////////////
// Shared cache types
// Address field widths, data types, FSM states
////////////////////////////////////////
`include "cache_params.svh"

package cachePkg;

  // Word address is {tag, set, offset}
  localparam int OFFSET_BITS = $clog2(`CACHE_WORDS_PER_LINE);
  localparam int SET_BITS    = $clog2(`CACHE_SETS);
  localparam int TAG_BITS    = `CACHE_ADR_BITS - SET_BITS - OFFSET_BITS;

  typedef logic [`CACHE_WORD_BITS-1:0]      wordT;
  typedef wordT [`CACHE_WORDS_PER_LINE-1:0] lineT;    // Bus and array payload
  typedef logic [TAG_BITS-1:0]              tagT;
  typedef logic [SET_BITS-1:0]              setIdxT;
  typedef logic [$clog2(`CACHE_WAYS)-1:0]   wayIdxT;  // One bit
  typedef logic [OFFSET_BITS-1:0]           offsetT;

  // Controller states
  typedef enum logic [2:0] {
    READY,
    FETCH,
    WRITEBACK,
    WRITE_LINE,
    READ_HOLD,
    FLUSH,
    FLUSH_WRITEBACK
  } cacheStateT;

endpackage

/* design/cacheTagArray.sv */
////////////////////////////////////////
// Tag, valid, dirty and LRU storage
// Hit check, victim pick, bus address
////////////////////////////////////////
`timescale 1ns/1ps
`include "cache_params.svh"

module cacheTagArray (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`CACHE_ADR_BITS-1:0]  adr,
  input  logic                        selWriteback,
  input  logic                        selFlush,
  input  cachePkg::setIdxT            flushSet,
  input  cachePkg::wayIdxT            flushWay,
  input  logic                        setValid,
  input  logic                        setDirty,
  input  logic                        clearDirty,
  input  logic                        lruWriteEn,
  input  logic                        invalidateCache,
  output logic                        cacheHit,
  output logic                        lineDirty,
  output cachePkg::wayIdxT            selectedWay,
  output logic [`CACHE_ADR_BITS-1:0]  busAdr
);

  cachePkg::tagT    tags [`CACHE_WAYS][`CACHE_SETS];   // Payload only
  logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] valid;
  logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] dirty;
  logic [`CACHE_SETS-1:0] lru;                           // Way to evict next

  cachePkg::tagT    adrTag;
  cachePkg::setIdxT adrSet;
  cachePkg::setIdxT setIdx;
  cachePkg::tagT    wayTag;
  logic [`CACHE_WAYS-1:0] hitWay;
  cachePkg::wayIdxT hitWayIdx;
  cachePkg::wayIdxT victimWay;

  // Split off the tag and set, offset unused here
  assign {adrTag, adrSet} = adr[`CACHE_ADR_BITS-1:cachePkg::OFFSET_BITS];
  assign setIdx = selFlush ? flushSet : adrSet;   // Flush walks its own sets

  ////////////////////////////////////////
  // Hit and victim
  ////////////////////////////////////////
  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      hitWay[w] = valid[w][setIdx] & (tags[w][setIdx] == adrTag);
    end
  end

  assign cacheHit  = |hitWay;
  assign hitWayIdx = cachePkg::wayIdxT'(hitWay[1]);   // Two ways only

  // First invalid way, else LRU
  always_comb begin
    if (!valid[0][setIdx]) begin
      victimWay = 1'b0;
    end else if (!valid[1][setIdx]) begin
      victimWay = 1'b1;
    end else begin
      victimWay = lru[setIdx];
    end
  end

  assign selectedWay = selFlush ? flushWay : (cacheHit ? hitWayIdx : victimWay);
  assign lineDirty   = valid[selectedWay][setIdx] & dirty[selectedWay][setIdx];
  assign wayTag      = tags[selectedWay][setIdx];

  // Line aligned address, victim tag on writeback or flush
  assign busAdr = (selWriteback | selFlush) ?
                  {wayTag, setIdx, cachePkg::offsetT'(0)} :
                  {adrTag, setIdx, cachePkg::offsetT'(0)};

  ////////////////////////////////////////
  // State updates
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      dirty <= '0;
      lru   <= '0;
    end else if (invalidateCache) begin
      valid <= '0;   // Whole cache in one cycle
      dirty <= '0;
    end else begin
      if (setValid) valid[selectedWay][setIdx] <= 1'b1;
      if (setDirty) begin
        dirty[selectedWay][setIdx] <= 1'b1;
      end else if (clearDirty) begin
        dirty[selectedWay][setIdx] <= 1'b0;
      end
      if (lruWriteEn) lru[setIdx] <= ~selectedWay;   // Other way now oldest
    end
  end

  // New tag goes in with the line fill
  always_ff @(posedge clk) begin
    if (setValid) tags[selectedWay][setIdx] <= adrTag;
  end

  // Fills never leave a tag in both ways of a set
  assert property (@(posedge clk) disable iff (reset) !(hitWay[0] && hitWay[1]))
    else $error("Both ways hit in set %0d", setIdx);

endmodule

/* design/cacheTop.sv */
////////////////////////////////////////
// Data cache top level
// Controller, tag and data arrays, flush counters
////////////////////////////////////////
`timescale 1ns/1ps
`include "cache_params.svh"

module cacheTop (
  input  logic                        clk,
  input  logic                        reset,
  // CPU side
  input  logic [1:0]                  cacheRW,
  input  logic [`CACHE_ADR_BITS-1:0]  adr,
  input  cachePkg::wordT              writeData,
  input  logic                        stall,
  input  logic                        flushCache,
  input  logic                        invalidateCache,
  output cachePkg::wordT              readData,
  output logic                        cacheStall,
  output logic                        cacheMiss,
  output logic                        cacheAccess,
  // Bus side
  output logic [1:0]                  busRW,
  output logic [`CACHE_ADR_BITS-1:0]  busAdr,
  output cachePkg::lineT              busWriteLine,
  input  cachePkg::lineT              busReadLine,
  input  logic                        busAck
);

  logic cacheHit;
  logic lineDirty;
  logic selWriteback;
  logic selFlush;
  logic setValid;
  logic setDirty;
  logic clearDirty;
  logic lruWriteEn;
  logic flushAdrCntEn;
  logic flushWayCntEn;
  logic flushCntRst;
  logic flushAdrFlag;
  logic flushWayFlag;
  logic selFetchBuffer;
  cachePkg::setIdxT flushSet;
  cachePkg::wayIdxT flushWay;
  cachePkg::wayIdxT selectedWay;
  logic [`CACHE_ADR_BITS-1:0] dataAdr;

  // Data array follows the flush set during a flush
  assign dataAdr = selFlush ? {cachePkg::tagT'(0), flushSet, cachePkg::offsetT'(0)} : adr;

  cacheFsm fsm (
    .clk, .reset, .stall, .cacheRW, .flushCache, .invalidateCache, .busAck,
    .cacheHit, .lineDirty, .flushAdrFlag, .flushWayFlag,
    .cacheStall, .busRW, .cacheMiss, .cacheAccess, .selWriteback, .selFlush,
    .setValid, .setDirty, .clearDirty, .lruWriteEn,
    .flushAdrCntEn, .flushWayCntEn, .flushCntRst, .selFetchBuffer
  );

  cacheTagArray tagArray (
    .clk, .reset, .adr, .selWriteback, .selFlush, .flushSet, .flushWay,
    .setValid, .setDirty, .clearDirty, .lruWriteEn, .invalidateCache,
    .cacheHit, .lineDirty, .selectedWay, .busAdr
  );

  cacheDataArray dataArray (
    .clk, .adr(dataAdr), .selectedWay, .writeData, .cacheRW, .setValid, .setDirty,
    .busReadLine, .busAck, .selFetchBuffer, .readData, .busWriteLine
  );

  flushCounter flushCnt (
    .clk, .reset, .flushAdrCntEn, .flushWayCntEn, .flushCntRst,
    .flushSet, .flushWay, .flushAdrFlag, .flushWayFlag
  );

endmodule

/* design/cache_params.svh */
////////////////////////////////////////
// Geometry macros for the data cache
// Word, line, set, way and address sizes
////////////////////////////////////////
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Data word width in bits
`define CACHE_WORD_BITS 32

// Words in one line
`define CACHE_WORDS_PER_LINE 4

`define CACHE_SETS 4   // Sets per way

// Two ways only since the LRU is a single bit per set
`define CACHE_WAYS 2

`define CACHE_ADR_BITS 12   // Word address from the CPU

`endif

/* design/flushCounter.sv */
////////////////////////////////////////
// Flush walk counters
// Set and way counts, last-entry flags
////////////////////////////////////////
`timescale 1ns/1ps
`include "cache_params.svh"

module flushCounter (
  input  logic             clk,
  input  logic             reset,
  input  logic             flushAdrCntEn,   // Next set
  input  logic             flushWayCntEn,   // Next way
  input  logic             flushCntRst,     // Walk finished
  output cachePkg::setIdxT flushSet,
  output cachePkg::wayIdxT flushWay,
  output logic             flushAdrFlag,
  output logic             flushWayFlag
);

  always_ff @(posedge clk) begin
    if (reset | flushCntRst) begin
      flushSet <= '0;
      flushWay <= '0;
    end else begin
      if (flushAdrCntEn) flushSet <= flushSet + 1'b1;
      if (flushWayCntEn) flushWay <= flushWay + 1'b1;   // Wraps with the set step
    end
  end

  assign flushAdrFlag = flushSet == cachePkg::setIdxT'(`CACHE_SETS - 1);
  assign flushWayFlag = flushWay == cachePkg::wayIdxT'(`CACHE_WAYS - 1);

endmodule

/* testbench/cacheTbTasks.svh */
////////////////////////////////////////
// Directed cache tests
// Request helpers, reference tag model
////////////////////////////////////////
`ifndef CACHE_TB_TASKS_SVH
`define CACHE_TB_TASKS_SVH

task automatic startTest(input string name);
  curTest    = name;
  testErrors = 0;
endtask

task automatic endTest();
  $display("%-18s %0d errors", curTest, testErrors);
endtask

task automatic checkValue(input string what, input logic [31:0] exp, input logic [31:0] act);
  checks++;
  assert (act === exp) else begin
    errors++;
    testErrors++;
    $display("ERR %s %s: expected %h, actual %h", curTest, what, exp, act);
  end
endtask

task automatic clearModel();
  for (int s = 0; s < `CACHE_SETS; s++) begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      modelValid[s][w] = 1'b0;
      modelDirty[s][w] = 1'b0;
    end
  end
endtask

// Hit check and fill, first invalid way else LRU
function automatic bit modelAccess(input logic [`CACHE_ADR_BITS-1:0] a, input bit isWrite);
  int s;
  int w;
  bit hit;
  cachePkg::tagT t;
  s   = a[cachePkg::OFFSET_BITS +: cachePkg::SET_BITS];
  t   = a[`CACHE_ADR_BITS-1 -: cachePkg::TAG_BITS];
  hit = 1'b0;
  w   = 0;
  for (int i = 0; i < `CACHE_WAYS; i++) begin
    if (modelValid[s][i] && modelTag[s][i] == t) begin
      hit = 1'b1;
      w   = i;
    end
  end
  if (!hit) begin
    if (!modelValid[s][0]) w = 0;
    else if (!modelValid[s][1]) w = 1;
    else w = modelLru[s];
    modelValid[s][w] = 1'b1;
    modelTag[s][w]   = t;
    modelDirty[s][w] = 1'b0;   // Fresh fill
  end
  if (isWrite) modelDirty[s][w] = 1'b1;
  modelLru[s] = (w == 0);   // Other way is now oldest
  return hit;
endfunction

// Waits mid cycle for cacheStall low
task automatic waitReady(input string what);
  int cycles;
  cycles = 0;
  do begin
    @(negedge clk);
    cycles++;
  end while (cacheStall && cycles < TIMEOUT);
  assert (!cacheStall) else begin
    errors++;
    testErrors++;
    $display("%s: %s still stalled after %0d cycles", curTest, what, TIMEOUT);
  end
endtask

// One CPU request, read data checked on completion
task automatic request(input logic [1:0] rw, input logic [`CACHE_ADR_BITS-1:0] a,
                       input cachePkg::wordT d, output bit missed);
  cachePkg::wordT rd;
  requests++;
  if (!modelAccess(a, rw[0])) predictedMisses++;
  cacheRW   = rw;
  adr       = a;
  writeData = d;
  waitReady("request");
  rd     = readData;
  missed = cacheMiss;
  @(posedge clk);   // Request completes here
  #2;
  cacheRW = 2'b00;
  if (rw[0]) refMem[a] = d;
  else checkValue("read data", refMem[a], rd);
endtask

task automatic flushAll();
  flushCache = 1'b1;
  waitReady("flush");
  @(posedge clk);
  #2;
  flushCache = 1'b0;
  for (int s = 0; s < `CACHE_SETS; s++) begin
    for (int w = 0; w < `CACHE_WAYS; w++) modelDirty[s][w] = 1'b0;
  end
endtask

task automatic invalidateAll();
  invalidateCache = 1'b1;
  waitReady("invalidate");
  @(posedge clk);   // All valid bits drop here
  #2;
  invalidateCache = 1'b0;
  clearModel();
endtask

////////////////////////////////////////
// Tests
////////////////////////////////////////
task automatic readMissThenHit();
  bit missed;
  int fetches;
  startTest("readMissThenHit");
  checkValue("idle outputs", 0, {cacheStall, busRW, cacheMiss, cacheAccess});
  request(2'b10, 12'h104, '0, missed);
  checkValue("first read miss", 1, missed);
  fetches = busFetches;
  request(2'b10, 12'h106, '0, missed);   // Same line
  checkValue("second read miss", 0, missed);
  checkValue("fetches on hit", fetches, busFetches);
  endTest();
endtask

task automatic writeHitEviction();
  bit missed;
  int wbs;
  startTest("writeHitEviction");
  wbs = busWritebacks;
  request(2'b01, 12'h106, 32'h5a5a1234, missed);
  checkValue("write hit miss", 0, missed);
  request(2'b10, 12'h206, '0, missed);   // Fills the free way
  request(2'b10, 12'h306, '0, missed);   // Evicts the dirty line
  checkValue("writebacks", wbs + 1, busWritebacks);
  checkValue("written back word", 32'h5a5a1234, mem[12'h106]);
  endTest();
endtask

// Set 2, tags 0x00, 0x10, 0x20
task automatic lruVictim();
  logic [`CACHE_ADR_BITS-1:0] seq [6];
  bit expMiss [6];
  bit missed;
  startTest("lruVictim");
  seq     = '{12'h008, 12'h108, 12'h00a, 12'h208, 12'h009, 12'h10b};
  expMiss = '{1, 1, 0, 1, 0, 1};
  for (int i = 0; i < 6; i++) begin
    request(2'b10, seq[i], '0, missed);
    checkValue("miss flag", expMiss[i], missed);
    if (expMiss[i]) checkValue("fetched line", seq[i] & 12'hffc, lastFetchAdr);
  end
  endTest();
endtask

task automatic flushDirty();
  bit missed;
  int dirtyLines;
  int wbs;
  int twice;
  int mismatches;
  startTest("flushDirty");
  request(2'b01, 12'h00c, 32'hc0de0001, missed);   // Set 3 write miss
  request(2'b01, 12'h10d, 32'hc0de0002, missed);   // Set 3 other way
  request(2'b01, 12'h009, 32'hc0de0003, missed);   // Set 2 write hit
  request(2'b01, 12'h031, 32'hc0de0004, missed);   // Set 0
  dirtyLines = 0;
  for (int s = 0; s < `CACHE_SETS; s++) begin
    for (int w = 0; w < `CACHE_WAYS; w++) dirtyLines += modelDirty[s][w];
  end
  foreach (wbPerLine[i]) wbPerLine[i] = 0;
  wbs = busWritebacks;
  flushAll();
  checkValue("flush writebacks", dirtyLines, busWritebacks - wbs);
  twice      = 0;
  mismatches = 0;
  foreach (wbPerLine[i]) if (wbPerLine[i] > 1) twice++;
  foreach (mem[a]) if (mem[a] !== refMem[a]) mismatches++;
  checkValue("lines written twice", 0, twice);
  checkValue("memory mismatches", 0, mismatches);
  endTest();
endtask

task automatic invalidateMiss();
  bit missed;
  int fetches;
  startTest("invalidateMiss");
  request(2'b10, 12'h009, '0, missed);
  checkValue("cached read miss", 0, missed);
  invalidateAll();
  fetches = busFetches;
  request(2'b10, 12'h009, '0, missed);
  checkValue("miss after invalidate", 1, missed);
  checkValue("fetches after invalidate", fetches + 1, busFetches);
  endTest();
endtask

// Random mix over 16 tags, then the pulse totals
task automatic pulseCounts();
  bit missed;
  logic [1:0] rw;
  logic [`CACHE_ADR_BITS-1:0] a;
  startTest("pulseCounts");
  for (int i = 0; i < 24; i++) begin
    a  = `CACHE_ADR_BITS'({$random(seed)} & 32'hff);
    rw = ({$random(seed)} % 3 == 0) ? 2'b01 : 2'b10;
    request(rw, a, $random(seed), missed);
  end
  checkValue("access pulses", requests, accessPulses);
  checkValue("miss pulses", predictedMisses, missPulses);
  endTest();
endtask

`endif

/* testbench/cacheTb.sv */
////////////////////////////////////////
// Data cache testbench
// Clock, reset, DUT, memory model, run
////////////////////////////////////////
`timescale 1ns/1ps
`include "cache_params.svh"

module cacheTb;

  localparam int MEM_WORDS = 1 << `CACHE_ADR_BITS;
  localparam int TIMEOUT   = 200;   // Cycles per wait

  logic                       clk;
  logic                       reset;
  logic [1:0]                 cacheRW;
  logic [`CACHE_ADR_BITS-1:0] adr;
  cachePkg::wordT             writeData;
  logic                       stall;
  logic                       flushCache;
  logic                       invalidateCache;
  cachePkg::wordT             readData;
  logic                       cacheStall;
  logic                       cacheMiss;
  logic                       cacheAccess;
  logic [1:0]                 busRW;
  logic [`CACHE_ADR_BITS-1:0] busAdr;
  cachePkg::lineT             busWriteLine;
  cachePkg::lineT             busReadLine;
  logic                       busAck;

  cachePkg::wordT mem [MEM_WORDS];      // Memory behind the bus
  cachePkg::wordT refMem [MEM_WORDS];   // Expected CPU view
  int wbPerLine [MEM_WORDS/`CACHE_WORDS_PER_LINE];
  integer seed = 32'hcf72e5db;
  int busFetches;
  int busWritebacks;
  int lastFetchAdr;
  int accessPulses;
  int missPulses;
  int checks;
  int errors;
  int testErrors;
  int requests;
  int predictedMisses;
  string curTest;

  // Reference tag model
  bit            modelValid [`CACHE_SETS][`CACHE_WAYS];
  bit            modelDirty [`CACHE_SETS][`CACHE_WAYS];
  cachePkg::tagT modelTag [`CACHE_SETS][`CACHE_WAYS];
  bit            modelLru [`CACHE_SETS];   // Way to evict next

  always #10 clk = ~clk;

  cacheTop UUT (.*);

  `include "cacheTbTasks.svh"

  ////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////
  always begin
    int delay;
    int base;
    logic [1:0] kind;
    @(negedge clk);
    if (!reset && busRW != 2'b00) begin
      kind  = busRW;
      base  = busAdr;   // Line aligned
      delay = 1 + ({$random(seed)} % 4);
      repeat (delay) @(posedge clk);
      #2;
      if (kind[0]) begin
        for (int i = 0; i < `CACHE_WORDS_PER_LINE; i++) begin
          mem[base + i] = busWriteLine[i];
        end
        wbPerLine[base / `CACHE_WORDS_PER_LINE]++;
        busWritebacks++;
      end else begin
        for (int i = 0; i < `CACHE_WORDS_PER_LINE; i++) begin
          busReadLine[i] = mem[base + i];
        end
        lastFetchAdr = base;
        busFetches++;
      end
      busAck = 1'b1;   // One cycle pulse
      @(posedge clk);
      #2;
      busAck = 1'b0;
    end
  end

  // Pulse counters, sampled mid cycle
  always @(negedge clk) begin
    if (!reset && cacheAccess) accessPulses++;
    if (!reset && cacheMiss) missPulses++;
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    clk             = 1'b0;
    reset           = 1'b1;
    cacheRW         = 2'b00;
    adr             = '0;
    writeData       = '0;
    stall           = 1'b0;
    flushCache      = 1'b0;
    invalidateCache = 1'b0;
    busReadLine     = '0;
    busAck          = 1'b0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a]    = $random(seed);
      refMem[a] = mem[a];
    end
    clearModel();
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;

    readMissThenHit();
    writeHitEviction();
    lruVictim();
    flushDirty();
    invalidateMiss();
    pulseCounts();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
